// ==== src.f ====
hw/rv_pkg.sv
hw/rf_if.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/core_ctrl.sv
hw/rv_core_top.sv
bench/rv_core_checker.sv
bench/tb_rv_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f src.f
	./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

    localparam int          RESET_CYCLES     = 16;
    localparam int          CYCLES_PER_INSTR = 40;
    localparam logic [31:0] RESULT_BASE      = 32'h0000_0200;
    localparam logic [31:0] DATA_ADDR        = 32'h0000_03f0;
    localparam logic [31:0] MARKER           = 32'h600d_0001;

    logic        clk = 1'b0;
    logic        rst;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [31:0] mem [256];
    logic [31:0] prog_pc;
    logic [31:0] res_addr;
    int          prog_words = 0;
    int          errors = 0;
    int          checks = 0;

    logic [31:0] exp_addr [$];
    logic [31:0] exp_val [$];
    string       exp_name [$];

    logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    logic       r_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    string      r_name [10] = '{"ADD", "SUB", "AND", "OR", "XOR", "SLT", "SLTU", "SLL",
                                "SRL", "SRA"};
    logic [2:0] i_f3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    logic       i_alt [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    string      i_name [9] = '{"ADDI", "SLTI", "SLTIU", "XORI", "ORI", "ANDI", "SLLI",
                               "SRLI", "SRAI"};
    logic [2:0] b_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    string      b_name [6] = '{"BEQ", "BNE", "BLT", "BGE", "BLTU", "BGEU"};

    always #5 clk = ~clk;

    rv_core_top #(
        .DATAWIDTH   (32),
        .SHIFT_WIDTH (5)
    ) DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .halted_o    (halted)
    );

    bind rv_core_top rv_core_checker u_checker (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mem_req_i (mem_req_o),
        .halted_i  (halted_o),
        .rf_we_i   (rf_bus.we),
        .rf_ra1_i  (rf_bus.ra1),
        .rf_rd1_i  (rf_bus.rd1)
    );

    // memory answers a read one cycle after the strobe
    always @(posedge clk) begin
        if (mem_req) begin
            if (mem_we) begin
                mem[mem_addr[9:2]] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr[9:2]];
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {16'hc0de, idx, ~idx};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_R};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BR};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    // RV32I integer semantics, selected by funct3 and the funct7 alternate bit
    function automatic logic [31:0] op_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? (a - b) : (a + b);
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> sh) : (a >> sh);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[prog_pc[9:2]] = w;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit({upper[19:0], rd, rv_pkg::OP_LUI});
        emit(i_type(v[11:0], rd, 3'd0, rd, rv_pkg::OP_I));
    endtask

    // a skipped store leaves the fill word in place
    task automatic store_check(input logic [4:0] rs, input logic [31:0] v,
                               input logic skipped, input string name);
        emit(s_type(res_addr[11:0], rs, 5'd0));
        exp_addr.push_back(res_addr);
        exp_val.push_back(skipped ? fill_word(res_addr[9:2]) : v);
        exp_name.push_back(name);
        res_addr = res_addr + 32'd4;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pa [3];
        logic [31:0] pb [3];
        logic [11:0] imm;
        logic [31:0] jal_pc;
        logic [31:0] data;
        prog_pc  = rv_pkg::RESET_PC;
        res_addr = RESULT_BASE;
        // negative a against positive b separates signed from unsigned compares
        a = $urandom() | 32'h8000_0000;
        b = $urandom() & 32'h7fff_ffff;
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(r_type({1'b0, r_alt[k], 5'b0}, 5'd2, 5'd1, r_f3[k], 5'd3));
            store_check(5'd3, op_result(r_f3[k], r_alt[k], a, b), 1'b0, r_name[k]);
        end
        for (int k = 0; k < 9; k++) begin
            imm = 12'($urandom());
            if ((i_f3[k] == 3'd1) || (i_f3[k] == 3'd5)) begin
                imm = {1'b0, i_alt[k], 5'b0, imm[4:0]};
            end
            emit(i_type(imm, 5'd1, i_f3[k], 5'd4, rv_pkg::OP_I));
            store_check(5'd4, op_result(i_f3[k], i_alt[k], a, {{20{imm[11]}}, imm}), 1'b0,
                        i_name[k]);
        end
        load_const(5'd7, MARKER);
        pa[0] = $urandom();
        pb[0] = pa[0];
        pa[1] = $urandom() | 32'h8000_0000;
        pb[1] = $urandom() & 32'h7fff_ffff;
        pa[2] = pb[1];
        pb[2] = pa[1];
        for (int p = 0; p < 3; p++) begin
            load_const(5'd5, pa[p]);
            load_const(5'd6, pb[p]);
            for (int k = 0; k < 6; k++) begin
                emit(b_type(13'd8, 5'd6, 5'd5, b_f3[k]));
                store_check(5'd7, MARKER, branch_taken(b_f3[k], pa[p], pb[p]), b_name[k]);
            end
        end
        jal_pc = prog_pc;
        emit(j_type(21'd8, 5'd8));
        store_check(5'd7, MARKER, 1'b1, "JAL skip");
        store_check(5'd8, jal_pc + 32'd4, 1'b0, "JAL link");
        data = $urandom();
        mem[DATA_ADDR[9:2]] = data;
        emit(i_type(DATA_ADDR[11:0], 5'd0, 3'b010, 5'd9, rv_pkg::OP_LOAD));
        store_check(5'd9, data, 1'b0, "LW copy");
        emit(i_type(12'd123, 5'd0, 3'd0, 5'd0, rv_pkg::OP_I));
        store_check(5'd0, 32'd0, 1'b0, "x0 write");
        // ecall
        emit(32'h0000_0073);
        prog_words = int'(prog_pc >> 2);
    endtask

    initial begin
        logic [31:0] got;
        void'($urandom(32'h9dd9_b32d));
        rst       = 1'b1;
        mem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (!halted) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        for (int i = 0; i < exp_addr.size(); i++) begin
            checks++;
            got = mem[exp_addr[i][9:2]];
            assert (got == exp_val[i]) else begin
                errors++;
                $display("[FAIL] %s expected %08h actual %08h", exp_name[i], exp_val[i], got);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // budget scales with program length
    initial begin
        wait (prog_words > 0);
        repeat (RESET_CYCLES + prog_words * CYCLES_PER_INSTR) @(posedge clk);
        $display("timeout: core did not reach halt within the cycle budget");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== bench/rv_core_checker.sv ====
`timescale 1ns/1ns

module rv_core_checker (
    input logic             clk_i,
    input logic             rst_i,
    input logic             mem_req_i,
    input logic             halted_i,
    input logic             rf_we_i,
    input rv_pkg::reg_idx_t rf_ra1_i,
    input rv_pkg::word_t    rf_rd1_i
);

    // fetch and data strobes are always separated by at least one idle cycle
    no_back_to_back_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_i |=> !mem_req_i
    ) else $error("memory strobe high in two consecutive cycles");

    quiet_in_reset: assert property (
        @(posedge clk_i)
        rst_i |-> (!mem_req_i && !rf_we_i && !halted_i)
    ) else $error("bus or register write active during reset");

    // first cycle out of reset is still idle
    quiet_after_reset: assert property (
        @(posedge clk_i)
        (!rst_i && $past(rst_i)) |-> (!mem_req_i && !rf_we_i && !halted_i)
    ) else $error("bus or register write active in the cycle after reset");

    halt_is_sticky: assert property (
        @(posedge clk_i) disable iff (rst_i)
        halted_i |=> (halted_i && !mem_req_i)
    ) else $error("core left halt or touched the bus after halting");

    x0_reads_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (rf_ra1_i == '0) |-> (rf_rd1_i == '0)
    ) else $error("x0 read back a nonzero value");

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top #(
    parameter int DATAWIDTH   = rv_pkg::XLEN,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    output logic          mem_req_o,
    output logic          mem_we_o,
    output rv_pkg::addr_t mem_addr_o,
    output rv_pkg::word_t mem_wdata_o,
    input  rv_pkg::word_t mem_rdata_i,
    output logic          halted_o
);

    rv_pkg::word_t    instr;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    rv_pkg::alu_op_e  alu_op;
    rv_pkg::br_op_e   br_op;
    logic             use_imm;
    logic             reg_write;
    logic             is_branch;
    logic             is_jal;
    logic             is_load;
    logic             is_store;
    logic             is_halt;
    rv_pkg::word_t    src_a;
    rv_pkg::word_t    src_b;
    rv_pkg::word_t    alu_result;
    logic             branch;

    rf_if rf_bus ();

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rf    (rf_bus.rf)
    );

    instr_decoder u_decoder (
        .instr_i     (instr),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .br_op_o     (br_op),
        .use_imm_o   (use_imm),
        .reg_write_o (reg_write),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_halt_o   (is_halt)
    );

    alu #(
        .DATAWIDTH   (DATAWIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) u_alu (
        .src_a_i  (src_a),
        .src_b_i  (src_b),
        .alu_op_i (alu_op),
        .br_op_i  (br_op),
        .result_o (alu_result),
        .branch_o (branch)
    );

    core_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_rdata_i  (mem_rdata_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rd_i         (rd),
        .imm_i        (imm),
        .use_imm_i    (use_imm),
        .reg_write_i  (reg_write),
        .is_branch_i  (is_branch),
        .is_jal_i     (is_jal),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .is_halt_i    (is_halt),
        .alu_result_i (alu_result),
        .branch_i     (branch),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .instr_o      (instr),
        .src_a_o      (src_a),
        .src_b_o      (src_b),
        .halted_o     (halted_o),
        .rf           (rf_bus.ctrl)
    );

endmodule

// ==== hw/core_ctrl.sv ====
`timescale 1ns/1ns

module core_ctrl (
    input  logic             clk_i,
    input  logic             rst_i,
    input  rv_pkg::word_t    mem_rdata_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::word_t    imm_i,
    input  logic             use_imm_i,
    input  logic             reg_write_i,
    input  logic             is_branch_i,
    input  logic             is_jal_i,
    input  logic             is_load_i,
    input  logic             is_store_i,
    input  logic             is_halt_i,
    input  rv_pkg::word_t    alu_result_i,
    input  logic             branch_i,
    output logic             mem_req_o,
    output logic             mem_we_o,
    output rv_pkg::addr_t    mem_addr_o,
    output rv_pkg::word_t    mem_wdata_o,
    output rv_pkg::word_t    instr_o,
    output rv_pkg::word_t    src_a_o,
    output rv_pkg::word_t    src_b_o,
    output logic             halted_o,
    rf_if.ctrl               rf
);

    rv_pkg::ctrl_state_e state_q;
    rv_pkg::ctrl_state_e state_d;
    rv_pkg::addr_t       pc_q;
    rv_pkg::addr_t       pc_plus4;
    rv_pkg::addr_t       pc_target;
    rv_pkg::addr_t       pc_next;
    rv_pkg::word_t       ir_q;
    logic                started_q;

    // separate adder for branch and jump targets
    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm_i;
    assign pc_next   = ((is_branch_i && branch_i) || is_jal_i) ? pc_target : pc_plus4;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_pkg::FETCH: begin
                // first fetch waits one cycle after reset
                if (started_q) begin
                    state_d = rv_pkg::DECODE;
                end
            end
            rv_pkg::DECODE: state_d = rv_pkg::EXEC;
            rv_pkg::EXEC: begin
                if (is_halt_i) begin
                    state_d = rv_pkg::HALT;
                end else if (is_load_i || is_store_i) begin
                    state_d = rv_pkg::MEM;
                end else begin
                    state_d = rv_pkg::FETCH;
                end
            end
            rv_pkg::MEM:      state_d = rv_pkg::MEM_WAIT;
            // read data lands here; after a write this is a gap before the next fetch
            rv_pkg::MEM_WAIT: state_d = rv_pkg::FETCH;
            rv_pkg::HALT:     state_d = rv_pkg::HALT;
            default:          state_d = rv_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= rv_pkg::FETCH;
            pc_q      <= rv_pkg::RESET_PC;
            started_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= 1'b1;
            if ((state_q == rv_pkg::EXEC) && (state_d == rv_pkg::FETCH)) begin
                pc_q <= pc_next;
            end else if (state_q == rv_pkg::MEM_WAIT) begin
                pc_q <= pc_plus4;
            end
        end
    end

    // instruction word is valid the cycle after the fetch strobe
    always_ff @(posedge clk_i) begin
        if (state_q == rv_pkg::DECODE) begin
            ir_q <= mem_rdata_i;
        end
    end

    assign instr_o  = ir_q;
    assign halted_o = (state_q == rv_pkg::HALT);

    assign mem_req_o   = ((state_q == rv_pkg::FETCH) && started_q) || (state_q == rv_pkg::MEM);
    assign mem_we_o    = (state_q == rv_pkg::MEM) && is_store_i;
    assign mem_addr_o  = (state_q == rv_pkg::MEM) ? alu_result_i : pc_q;
    assign mem_wdata_o = rf.rd2;

    assign src_a_o = rf.rd1;
    assign src_b_o = use_imm_i ? imm_i : rf.rd2;

    assign rf.ra1 = rs1_i;
    assign rf.ra2 = rs2_i;
    assign rf.wa  = rd_i;
    assign rf.we  = ((state_q == rv_pkg::EXEC) && reg_write_i && !is_load_i)
                 || ((state_q == rv_pkg::MEM_WAIT) && is_load_i);
    assign rf.wd  = (state_q == rv_pkg::MEM_WAIT) ? mem_rdata_i
                  : (is_jal_i ? pc_plus4 : alu_result_i);

endmodule

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
    input  rv_pkg::word_t    instr_i,
    output rv_pkg::reg_idx_t rs1_o,
    output rv_pkg::reg_idx_t rs2_o,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::word_t    imm_o,
    output rv_pkg::alu_op_e  alu_op_o,
    output rv_pkg::br_op_e   br_op_o,
    output logic             use_imm_o,
    output logic             reg_write_o,
    output logic             is_branch_o,
    output logic             is_jal_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic             is_halt_o
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic          alt;
    rv_pkg::word_t imm_itype;
    rv_pkg::word_t imm_stype;
    rv_pkg::word_t imm_btype;
    rv_pkg::word_t imm_utype;
    rv_pkg::word_t imm_jtype;

    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  return sel_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return sel_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    // funct7 bit 5 selects SUB only for R-type, SRA/SRAI for both
    assign alt = instr_i[30] && ((opcode == rv_pkg::OP_R) || (funct3 == 3'b101));

    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_stype = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  br_op_o = rv_pkg::BR_BEQ;
            3'b001:  br_op_o = rv_pkg::BR_BNE;
            3'b100:  br_op_o = rv_pkg::BR_BLT;
            3'b101:  br_op_o = rv_pkg::BR_BGE;
            3'b110:  br_op_o = rv_pkg::BR_BLTU;
            3'b111:  br_op_o = rv_pkg::BR_BGEU;
            default: br_op_o = rv_pkg::BR_BEQ;
        endcase
    end

    // unknown opcodes fall through as no-ops
    always_comb begin
        imm_o       = imm_itype;
        alu_op_o    = rv_pkg::ALU_ADD;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_halt_o   = 1'b0;
        case (opcode)
            rv_pkg::OP_R: begin
                reg_write_o = 1'b1;
                alu_op_o    = arith_op(funct3, alt);
            end
            rv_pkg::OP_I: begin
                reg_write_o = 1'b1;
                use_imm_o   = 1'b1;
                alu_op_o    = arith_op(funct3, alt);
            end
            rv_pkg::OP_LUI: begin
                reg_write_o = 1'b1;
                use_imm_o   = 1'b1;
                imm_o       = imm_utype;
                alu_op_o    = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OP_BR: begin
                is_branch_o = 1'b1;
                imm_o       = imm_btype;
            end
            rv_pkg::OP_JAL: begin
                is_jal_o    = 1'b1;
                reg_write_o = 1'b1;
                imm_o       = imm_jtype;
            end
            rv_pkg::OP_LOAD: begin
                is_load_o   = 1'b1;
                reg_write_o = 1'b1;
                use_imm_o   = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                is_store_o = 1'b1;
                use_imm_o  = 1'b1;
                imm_o      = imm_stype;
            end
            rv_pkg::OP_SYS: begin
                is_halt_o = (funct3 == 3'b000);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input logic clk_i,
    rf_if.rf    rf
);

    rv_pkg::word_t regs [32];

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (rf.we && (rf.wa != '0)) begin
            regs[rf.wa] <= rf.wd;
        end
    end

    // combinational reads with x0 hardwired to zero
    always_comb begin
        if (rf.ra1 == '0) begin
            rf.rd1 = '0;
        end else begin
            rf.rd1 = regs[rf.ra1];
        end
    end

    always_comb begin
        if (rf.ra2 == '0) begin
            rf.rd2 = '0;
        end else begin
            rf.rd2 = regs[rf.ra2];
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu #(
    parameter int DATAWIDTH   = rv_pkg::XLEN,
    parameter int SHIFT_WIDTH = 5
) (
    input  rv_pkg::word_t   src_a_i,
    input  rv_pkg::word_t   src_b_i,
    input  rv_pkg::alu_op_e alu_op_i,
    input  rv_pkg::br_op_e  br_op_i,
    output rv_pkg::word_t   result_o,
    output logic            branch_o
);

    logic signed [DATAWIDTH-1:0] a_s;
    logic signed [DATAWIDTH-1:0] b_s;
    rv_pkg::shamt_t              shamt;

    assign a_s   = src_a_i;
    assign b_s   = src_b_i;
    assign shamt = src_b_i[SHIFT_WIDTH-1:0];

    // branch condition on rs1 and rs2
    always_comb begin
        case (br_op_i)
            rv_pkg::BR_BEQ: begin
                branch_o = (src_a_i == src_b_i);
            end
            rv_pkg::BR_BNE: begin
                branch_o = (src_a_i != src_b_i);
            end
            rv_pkg::BR_BLT: begin
                branch_o = (a_s < b_s);
            end
            rv_pkg::BR_BGE: begin
                branch_o = (a_s >= b_s);
            end
            rv_pkg::BR_BLTU: begin
                branch_o = (src_a_i < src_b_i);
            end
            rv_pkg::BR_BGEU: begin
                branch_o = (src_a_i >= src_b_i);
            end
            default: begin
                branch_o = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:    result_o = src_a_i + src_b_i;
            rv_pkg::ALU_SUB:    result_o = src_a_i - src_b_i;
            rv_pkg::ALU_AND:    result_o = src_a_i & src_b_i;
            rv_pkg::ALU_OR:     result_o = src_a_i | src_b_i;
            rv_pkg::ALU_XOR:    result_o = src_a_i ^ src_b_i;
            rv_pkg::ALU_SLT:    result_o = rv_pkg::word_t'(a_s < b_s);
            rv_pkg::ALU_SLTU:   result_o = rv_pkg::word_t'(src_a_i < src_b_i);
            rv_pkg::ALU_SRL:    result_o = src_a_i >> shamt;
            rv_pkg::ALU_SLL:    result_o = src_a_i << shamt;
            // arithmetic shift keeps the sign of a
            rv_pkg::ALU_SRA:    result_o = a_s >>> shamt;
            rv_pkg::ALU_SLA:    result_o = a_s <<< shamt;
            rv_pkg::ALU_PASS_B: result_o = src_b_i;
            default:            result_o = '0;
        endcase
    end

endmodule

// ==== hw/rf_if.sv ====
`timescale 1ns/1ns

interface rf_if;

    rv_pkg::reg_idx_t ra1;
    rv_pkg::reg_idx_t ra2;
    rv_pkg::word_t    rd1;
    rv_pkg::word_t    rd2;
    logic             we;
    rv_pkg::reg_idx_t wa;
    rv_pkg::word_t    wd;

    modport ctrl (output ra1, ra2, we, wa, wd, input rd1, rd2);

    modport rf (input ra1, ra2, we, wa, wd, output rd1, rd2);

    // read-only view for assertions
    modport mon (input ra1, ra2, rd1, rd2, we, wa, wd);

endinterface

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [4:0]      shamt_t;

    // 4-bit alu control codes
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLT    = 4'b0101,
        ALU_SLTU   = 4'b0110,
        ALU_SRL    = 4'b0111,
        ALU_SLL    = 4'b1000,
        ALU_SRA    = 4'b1001,
        ALU_SLA    = 4'b1010,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b010,
        BR_BGE  = 3'b011,
        BR_BLTU = 3'b100,
        BR_BGEU = 3'b101
    } br_op_e;

    // major opcodes
    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_SYS   = 7'b1110011;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        MEM_WAIT,
        HALT
    } ctrl_state_e;

    localparam addr_t RESET_PC = '0;

endpackage
